// File: verilog/console_consts.svh
`ifndef CONSOLE_CONSTS_SVH
`define CONSOLE_CONSTS_SVH

// ----------------------------------------------------------------------
// Sampling periods in 37.5 MHz clock cycles
// ----------------------------------------------------------------------
`define PER_INIT    32'd37_500_000
`define PER_500HZ   32'd75_000
`define PER_1KHZ    32'd37_500
`define PER_2KHZ    32'd18_750
`define PER_4KHZ    32'd9_375
`define PER_8KHZ_A  32'd4_688
`define PER_8KHZ_B  32'd4_687

// Rate codes as seen on fsamp
`define CODE_INIT   4'd0
`define CODE_500HZ  4'd1
`define CODE_1KHZ   4'd2
`define CODE_2KHZ   4'd3
`define CODE_4KHZ   4'd4
`define CODE_8KHZ   4'd5

// ----------------------------------------------------------------------
// Widths and record tags
// ----------------------------------------------------------------------
`define RATE_W      4
`define LEVEL_W     8
`define SEQ_W       14
`define FRAME_W     6
`define FLEN_W      4
`define TAG_W       2
`define REC_W       32

`define TAG_SAMPLE  2'b01
`define TAG_SUMMARY 2'b10

`endif

// File: verilog/console_cfg_pkg.sv
`default_nettype none

`include "console_consts.svh"

package console_cfg_pkg;

    // Codes above RATE_8KHZ never get stored, cfg_regs folds them to RATE_INIT
    typedef enum logic [`RATE_W-1:0] {
        RATE_INIT  = `CODE_INIT,
        RATE_500HZ = `CODE_500HZ,
        RATE_1KHZ  = `CODE_1KHZ,
        RATE_2KHZ  = `CODE_2KHZ,
        RATE_4KHZ  = `CODE_4KHZ,
        RATE_8KHZ  = `CODE_8KHZ
    } rate_e;

    typedef struct packed {
        rate_e               rate;
        logic [`FLEN_W-1:0]  frame_len;  // 0 means 16 samples
    } cfg_t;

endpackage

`default_nettype wire

// File: verilog/console_data_pkg.sv
`default_nettype none

`include "console_consts.svh"

package console_data_pkg;

    typedef struct packed {
        logic [`SEQ_W-1:0]   seq;
        logic [`LEVEL_W-1:0] level;
    } sample_t;

    typedef struct packed {
        logic [`FRAME_W-1:0] frame;
        logic [`LEVEL_W-1:0] min;
        logic [`LEVEL_W-1:0] max;
    } summary_t;

    // ------------------------------------------------------------------
    // Output record, two views picked by the tag in bits 31:30
    // ------------------------------------------------------------------
    typedef struct packed {
        logic [`TAG_W-1:0]                          tag;
        logic [`SEQ_W-1:0]                          seq;
        logic [`REC_W-`TAG_W-`SEQ_W-`LEVEL_W-1:0]   rsvd;  // Always zero
        logic [`LEVEL_W-1:0]                        level;
    } rec_sample_t;

    typedef struct packed {
        logic [`TAG_W-1:0]   tag;
        logic [`FRAME_W-1:0] frame;
        logic [`LEVEL_W-1:0] min;
        logic [`LEVEL_W-1:0] max;
        logic [`LEVEL_W-1:0] span;
    } rec_summary_t;

    typedef union packed {
        rec_sample_t  smp;
        rec_summary_t sum;
    } record_u;

endpackage

`default_nettype wire

// File: verilog/console_cfg_regs.sv
`default_nettype none

`include "console_consts.svh"

module console_cfg_regs import console_cfg_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                fs_conf,
    input  logic [`RATE_W-1:0]  fsamp,
    input  logic [`FLEN_W-1:0]  frame_len,
    output cfg_t                cfg,
    output logic                restart
);

    rate_e sel_rate;

    // Unsupported codes run at the init rate
    always_comb begin
        if (fsamp > `CODE_8KHZ)
            sel_rate = RATE_INIT;
        else
            sel_rate = rate_e'(fsamp);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg.rate      <= RATE_INIT;
            cfg.frame_len <= '0;  // 16 samples
            restart       <= 1'b0;
        end else begin
            restart <= fs_conf;  // One cycle behind the strobe
            if (fs_conf) begin
                cfg.rate      <= sel_rate;
                cfg.frame_len <= frame_len;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/console_tick.sv
`default_nettype none

`include "console_consts.svh"

module console_tick import console_cfg_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  restart,
    input  rate_e rate,
    output logic  tick
);

    logic [31:0] cnt;
    logic [31:0] period;
    logic        phase;  // 8 kHz half: 0 = A, 1 = B
    logic        run;
    logic        wrap;

    // ------------------------------------------------------------------
    // Period lookup
    // ------------------------------------------------------------------
    always_comb begin
        case (rate)
            RATE_500HZ: period = `PER_500HZ;
            RATE_1KHZ:  period = `PER_1KHZ;
            RATE_2KHZ:  period = `PER_2KHZ;
            RATE_4KHZ:  period = `PER_4KHZ;
            RATE_8KHZ:  period = phase ? `PER_8KHZ_B : `PER_8KHZ_A;
            default:    period = `PER_INIT;
        endcase
    end

    // Last cycle of the current period
    assign wrap = run && (cnt == period - 32'd1);

    // ------------------------------------------------------------------
    // Period counter
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt   <= '0;
            phase <= 1'b0;
            run   <= 1'b0;  // Idle until first configuration
            tick  <= 1'b0;
        end else if (restart) begin
            cnt   <= '0;
            phase <= 1'b0;  // Always start with A
            run   <= 1'b1;
            tick  <= 1'b0;
        end else begin
            tick <= wrap;
            if (wrap) begin
                cnt <= '0;
                if (rate == RATE_8KHZ)
                    phase <= ~phase;
            end else if (run) begin
                cnt <= cnt + 32'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/console_sampler.sv
`default_nettype none

`include "console_consts.svh"

module console_sampler import console_data_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                restart,
    input  logic                tick,
    input  logic [`LEVEL_W-1:0] din,
    output sample_t             sample,
    output logic                sample_valid
);

    logic [`SEQ_W-1:0] seq_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seq_cnt      <= '0;
            sample_valid <= 1'b0;
        end else if (restart) begin
            seq_cnt      <= '0;
            sample_valid <= 1'b0;  // Drop a tick racing the restart
        end else begin
            sample_valid <= tick;
            if (tick)
                seq_cnt <= seq_cnt + 1'b1;  // Wraps
        end
    end

    always_ff @(posedge clk) begin
        if (tick) begin
            sample.seq   <= seq_cnt;
            sample.level <= din;
        end
    end

endmodule

`default_nettype wire

// File: verilog/console_frame_stats.sv
`default_nettype none

`include "console_consts.svh"

module console_frame_stats import console_data_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                restart,
    input  sample_t             sample,
    input  logic                sample_valid,
    input  logic [`FLEN_W-1:0]  frame_len,
    output summary_t            summary,
    output logic                summary_valid
);

    logic [`FLEN_W-1:0]  cnt;
    logic [`FLEN_W-1:0]  last_idx;
    logic [`FRAME_W-1:0] frame;
    logic [`LEVEL_W-1:0] run_min;
    logic [`LEVEL_W-1:0] run_max;
    logic [`LEVEL_W-1:0] new_min;
    logic [`LEVEL_W-1:0] new_max;
    logic                first;
    logic                last;

    assign last_idx = frame_len - 1'b1;  // 0 wraps to 15, so 16 samples
    assign first    = (cnt == '0);
    assign last     = (cnt == last_idx);

    // First sample of a frame seeds the statistics
    assign new_min = (first || sample.level < run_min) ? sample.level : run_min;
    assign new_max = (first || sample.level > run_max) ? sample.level : run_max;

    // ------------------------------------------------------------------
    // Frame control
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt           <= '0;
            frame         <= '0;
            summary_valid <= 1'b0;
        end else if (restart) begin
            cnt           <= '0;  // Partial frame is lost
            frame         <= '0;
            summary_valid <= 1'b0;
        end else begin
            summary_valid <= sample_valid && last;
            if (sample_valid) begin
                if (last) begin
                    cnt   <= '0;
                    frame <= frame + 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample_valid) begin
            run_min <= new_min;
            run_max <= new_max;
            if (last)
                summary <= '{frame: frame, min: new_min, max: new_max};
        end
    end

endmodule

`default_nettype wire

// File: verilog/console_record_mux.sv
`default_nettype none

`include "console_consts.svh"

module console_record_mux import console_data_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  sample_t  sample,
    input  logic     sample_valid,
    input  summary_t summary,
    input  logic     summary_valid,
    output record_u  rec,
    output logic     rec_valid
);

    record_u             smp_word;
    record_u             sum_word;
    logic [`LEVEL_W-1:0] span;

    assign span = summary.max - summary.min;

    // ------------------------------------------------------------------
    // Record packing
    // ------------------------------------------------------------------
    always_comb begin
        smp_word.smp.tag   = `TAG_SAMPLE;
        smp_word.smp.seq   = sample.seq;
        smp_word.smp.rsvd  = '0;
        smp_word.smp.level = sample.level;
    end

    always_comb begin
        sum_word.sum.tag   = `TAG_SUMMARY;
        sum_word.sum.frame = summary.frame;
        sum_word.sum.min   = summary.min;
        sum_word.sum.max   = summary.max;
        sum_word.sum.span  = span;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            rec_valid <= 1'b0;
        else
            rec_valid <= sample_valid || summary_valid;
    end

    // Summary trails its sample by a cycle, so one slot is enough
    always_ff @(posedge clk) begin
        if (sample_valid)
            rec <= smp_word;
        else if (summary_valid)
            rec <= sum_word;
    end

endmodule

`default_nettype wire

// File: verilog/console_top.sv
`default_nettype none

`include "console_consts.svh"

module console_top
    import console_cfg_pkg::*;
    import console_data_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                fs_conf,
    input  logic [`RATE_W-1:0]  fsamp,
    input  logic [`FLEN_W-1:0]  frame_len,
    input  logic [`LEVEL_W-1:0] din,
    output record_u             rec,
    output logic                rec_valid
);

    cfg_t     cfg;
    logic     restart;
    logic     tick;
    sample_t  sample;
    logic     sample_valid;
    summary_t summary;
    logic     summary_valid;

    console_cfg_regs console_cfg_regs_i (
        .clk       (clk),
        .rst       (rst),
        .fs_conf   (fs_conf),
        .fsamp     (fsamp),
        .frame_len (frame_len),
        .cfg       (cfg),
        .restart   (restart)
    );

    console_tick console_tick_i (
        .clk     (clk),
        .rst     (rst),
        .restart (restart),
        .rate    (cfg.rate),
        .tick    (tick)
    );

    console_sampler console_sampler_i (
        .clk          (clk),
        .rst          (rst),
        .restart      (restart),
        .tick         (tick),
        .din          (din),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

    console_frame_stats console_frame_stats_i (
        .clk           (clk),
        .rst           (rst),
        .restart       (restart),
        .sample        (sample),
        .sample_valid  (sample_valid),
        .frame_len     (cfg.frame_len),
        .summary       (summary),
        .summary_valid (summary_valid)
    );

    console_record_mux console_record_mux_i (
        .clk           (clk),
        .rst           (rst),
        .sample        (sample),
        .sample_valid  (sample_valid),
        .summary       (summary),
        .summary_valid (summary_valid),
        .rec           (rec),
        .rec_valid     (rec_valid)
    );

endmodule

`default_nettype wire

// File: dv/console_tb.sv
`default_nettype none

`include "console_consts.svh"

module console_tb import console_data_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    logic                clk;
    logic                rst;
    logic                fs_conf;
    logic [`RATE_W-1:0]  fsamp;
    logic [`FLEN_W-1:0]  frame_len;
    logic [`LEVEL_W-1:0] din;
    record_u             rec;
    logic                rec_valid;

    integer seed = 32'h2d04_f9e6;
    int     cyc;       // Count of rising edges seen
    int     conf_cyc;  // Edge that sampled the last fs_conf
    int     n_samples;
    int     n_summaries;

    console_top console_top_i (
        .clk       (clk),
        .rst       (rst),
        .fs_conf   (fs_conf),
        .fsamp     (fsamp),
        .frame_len (frame_len),
        .din       (din),
        .rec       (rec),
        .rec_valid (rec_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // Failure reporting and compare tasks
    // ----------------------------------------------------------------------
    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic report_mismatch(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        abort_run();
    endtask

    task automatic report_failure(input string msg);
        $display("%s (at %0t)", msg, $time);
        abort_run();
    endtask

    task automatic check_arrival(input string what, input int got, input int exp);
        if (got != exp)
            report_mismatch($sformatf("%s arrived at cycle %0d, expected cycle %0d",
                                      what, got, exp));
    endtask

    task automatic check_sample(input record_u got, input record_u exp);
        if (got !== exp)
            report_mismatch($sformatf(
                "sample got tag %0b seq %0d rsvd %02h level %02h, exp tag %0b seq %0d level %02h",
                got.smp.tag, got.smp.seq, got.smp.rsvd, got.smp.level,
                exp.smp.tag, exp.smp.seq, exp.smp.level));
    endtask

    // Fields shown as tag/frame/min/max/span
    task automatic check_summary(input record_u got, input record_u exp);
        if (got !== exp)
            report_mismatch($sformatf(
                "summary got %0b/%0d/%02h/%02h/%02h exp %0b/%0d/%02h/%02h/%02h",
                got.sum.tag, got.sum.frame, got.sum.min, got.sum.max, got.sum.span,
                exp.sum.tag, exp.sum.frame, exp.sum.min, exp.sum.max, exp.sum.span));
    endtask

    // ----------------------------------------------------------------------
    // Stimulus and reference model
    // ----------------------------------------------------------------------
    task automatic step();
        @(posedge clk);
        cyc++;
        #1;
        din = $random(seed);  // Fresh level every cycle
    endtask

    task automatic expect_quiet(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            step();
            if (rec_valid)
                report_mismatch($sformatf("unexpected record %08h in a quiet window", rec));
        end
    endtask

    task automatic configure(input logic [`RATE_W-1:0] code, input logic [`FLEN_W-1:0] flen);
        fs_conf   = 1'b1;
        fsamp     = code;
        frame_len = flen;
        step();
        if (rec_valid)
            report_mismatch($sformatf("unexpected record %08h at configuration", rec));
        conf_cyc  = cyc;
        fs_conf   = 1'b0;
        fsamp     = $random(seed);  // Must be ignored without the strobe
        frame_len = $random(seed);
    endtask

    // Rate table, 8 kHz alternates starting with the longer period
    function automatic int period_of(input logic [`RATE_W-1:0] code, input int k);
        case (code)
            `CODE_500HZ: return `PER_500HZ;
            `CODE_1KHZ:  return `PER_1KHZ;
            `CODE_2KHZ:  return `PER_2KHZ;
            `CODE_4KHZ:  return `PER_4KHZ;
            `CODE_8KHZ:  return (k % 2 == 0) ? `PER_8KHZ_A : `PER_8KHZ_B;
            default:     return `PER_INIT;
        endcase
    endfunction

    function automatic logic [`RATE_W-1:0] pick_rate(input logic [1:0] idx);
        case (idx)
            2'd0:    return `CODE_500HZ;
            2'd1:    return `CODE_2KHZ;
            2'd2:    return `CODE_4KHZ;
            default: return `CODE_8KHZ;
        endcase
    endfunction

    task automatic wait_record(input int due, input int tick_at, output int seen,
                               output logic [`LEVEL_W-1:0] lvl);
        int limit;
        limit = due + 16;
        lvl   = 'x;
        seen  = -1;
        while (seen < 0) begin
            step();
            if (cyc == tick_at)
                lvl = din;  // Model copy of the level under the tick
            if (rec_valid)
                seen = cyc;
            else if (cyc > limit)
                report_failure($sformatf("Timed out waiting for a record due at cycle %0d", due));
        end
    endtask

    task automatic run_samples(input logic [`RATE_W-1:0] code, input logic [`FLEN_W-1:0] flen,
                               input int nsamp);
        int                  flen_eff;
        int                  tick_at;
        int                  seen;
        int                  frame_no;
        int                  in_frame;
        logic [`LEVEL_W-1:0] lvl;
        logic [`LEVEL_W-1:0] unused_lvl;
        logic [`LEVEL_W-1:0] fmin;
        logic [`LEVEL_W-1:0] fmax;
        record_u             exp;

        flen_eff = (flen == 0) ? 16 : flen;
        tick_at  = conf_cyc + 1;  // Restart edge
        frame_no = 0;
        in_frame = 0;
        fmin     = '0;
        fmax     = '0;
        for (int k = 0; k < nsamp; k++) begin
            tick_at += period_of(code, k);
            wait_record(tick_at + 2, tick_at, seen, lvl);
            check_arrival("sample record", seen, tick_at + 2);
            exp           = '0;
            exp.smp.tag   = `TAG_SAMPLE;
            exp.smp.seq   = k[`SEQ_W-1:0];
            exp.smp.level = lvl;
            check_sample(rec, exp);
            n_samples++;

            if (in_frame == 0 || lvl < fmin)
                fmin = lvl;
            if (in_frame == 0 || lvl > fmax)
                fmax = lvl;
            in_frame++;

            if (in_frame == flen_eff) begin
                wait_record(tick_at + 3, -1, seen, unused_lvl);
                check_arrival("summary record", seen, tick_at + 3);
                exp           = '0;
                exp.sum.tag   = `TAG_SUMMARY;
                exp.sum.frame = frame_no[`FRAME_W-1:0];
                exp.sum.min   = fmin;
                exp.sum.max   = fmax;
                exp.sum.span  = fmax - fmin;
                check_summary(rec, exp);
                n_summaries++;
                frame_no++;
                in_frame = 0;
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------
    initial begin : main
        logic [`RATE_W-1:0] code;
        logic [`FLEN_W-1:0] flen;
        int                 nsamp;
        int                 rnd;

        rst         = 1'b1;
        fs_conf     = 1'b0;
        fsamp       = '0;
        frame_len   = '0;
        din         = '0;
        cyc         = 0;
        conf_cyc    = 0;
        n_samples   = 0;
        n_summaries = 0;

        for (int i = 0; i < 8; i++)
            step();
        rst = 1'b0;

        expect_quiet(64);  // Idle until the first strobe

        // Init rate and an unsupported code never tick in this window
        configure(`CODE_INIT, $random(seed));
        expect_quiet(200_000);
        rnd  = $random(seed);
        code = 4'd6 + (rnd[15:0] % 16'd10);
        configure(code, rnd[23:20]);
        expect_quiet(200_000);

        for (int n = 0; n < 8; n++) begin
            rnd   = $random(seed);
            code  = (n < 2) ? `CODE_8KHZ : pick_rate(rnd[9:8]);  // Two 8 kHz runs back to back
            flen  = rnd[7:4];
            nsamp = 2 * ((flen == 0) ? 16 : flen) + rnd[1:0];  // Two frames and a few extra
            if (n == 0)
                nsamp |= 1;  // Odd count leaves the 8 kHz phase on B
            configure(code, flen);
            run_samples(code, flen, nsamp);
        end

        $display("Checked %0d sample and %0d summary records", n_samples, n_summaries);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: console.f
+incdir+verilog
verilog/console_cfg_pkg.sv
verilog/console_data_pkg.sv
verilog/console_cfg_regs.sv
verilog/console_tick.sv
verilog/console_sampler.sv
verilog/console_frame_stats.sv
verilog/console_record_mux.sv
verilog/console_top.sv
dv/console_tb.sv

// File: Bender.yml
package:
  name: console

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/console_cfg_pkg.sv
      - verilog/console_data_pkg.sv
      - verilog/console_cfg_regs.sv
      - verilog/console_tick.sv
      - verilog/console_sampler.sv
      - verilog/console_frame_stats.sv
      - verilog/console_record_mux.sv
      - verilog/console_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/console_tb.sv
